/* tb.f */
source/poll_pkg.sv
source/slot_sequencer.sv
source/pulse_stretcher.sv
source/command_decoder.sv
source/status_writeback.sv
source/mem_port_mux.sv
source/user_command_gen.sv
dv/cmd_memory_model.sv
dv/tb_user_command_gen.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_user_command_gen
FILELIST   := tb.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_user_command_gen.sv */
module tb_user_command_gen
    import poll_pkg::*;
();

    localparam int SLOT_CLOCKS    = 10;
    localparam int SCAN_SLOTS     = 64;
    localparam int STRETCH_CLOCKS = 4;
    localparam int NUM_ROWS       = 6;
    localparam int NUM_SET        = 6;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 2) * SCAN_SLOTS * SLOT_CLOCKS;
    localparam int FIRST_READ_PHASE = 4;   // Slot 1 read reaches the port

    // Stimulus for one frame
    typedef struct packed {
        logic [STATUS_W-1:0]    status;
        logic [2:0][DATA_W-1:0] cmd;     // Index 0 reset, 1 start, 2 stop
        logic [2:0]             issue;   // Byte is expected to fire
    } frame_row_t;

    logic CLK;
    logic gen_reset;
    logic [DATA_W-1:0] mem_rdata;
    logic [STATUS_W-1:0] run_status;
    logic mem_en, mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata, chip_address;
    logic [ROW_W-1:0] row_read_start, row_read_end;
    logic [COL_W-1:0] column_read_start, column_read_end;
    logic [DELAY_W-1:0] time_delay;
    logic rst_pulse, rst, start_pulse, start, stop_pulse, stop;

    // Port A of the memory
    logic a_en, a_we;
    logic [ADDR_W-1:0] a_addr;
    logic [DATA_W-1:0] a_wdata, a_rdata, a_sample;

    frame_row_t rows [NUM_ROWS];
    int cmd_addr [3] = '{ADDR_RESET, ADDR_START, ADDR_STOP};
    int set_addr [NUM_SET] = '{ADDR_CHIP, ADDR_ROW_START, ADDR_ROW_END,
                               ADDR_COL_START, ADDR_COL_END, ADDR_DELAY};
    string cmd_name [3] = '{"rst", "start", "stop"};
    string set_name [NUM_SET] = '{"chip_address", "row_read_start", "row_read_end",
                                  "column_read_start", "column_read_end", "time_delay"};
    logic [31:0] rng;
    logic [SLOT_W-1:0] cur_slot;
    logic [PHASE_W-1:0] cur_phase;
    int pulse_cnt [3];
    int level_cnt [3];
    logic quiet_window;   // Reset until the first port read
    int cycle_cnt = 0;

    user_command_gen #(
        .SLOT_CLOCKS    (SLOT_CLOCKS),
        .SCAN_SLOTS     (SCAN_SLOTS),
        .STRETCH_CLOCKS (STRETCH_CLOCKS)
    ) i_dut (.*);

    cmd_memory_model i_memory (
        .CLK (CLK), .a_en (a_en), .a_we (a_we), .a_addr (a_addr), .a_wdata (a_wdata),
        .a_rdata (a_rdata), .b_en (mem_en), .b_we (mem_we), .b_addr (mem_addr),
        .b_wdata (mem_wdata), .b_rdata (mem_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the frames did not finish in %0d cycles", cycle_cnt));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Setting output idx zero-extended to one byte
    function automatic mem_word_u settings_word(input int idx);
        mem_word_u w;
        case (idx)
            0:       w.code = chip_address;
            1:       w.code = DATA_W'(row_read_start);
            2:       w.code = DATA_W'(row_read_end);
            3:       w.code = DATA_W'(column_read_start);
            4:       w.code = DATA_W'(column_read_end);
            default: w.code = DATA_W'(time_delay);
        endcase
        return w;
    endfunction

    function automatic mem_word_u expected_setting(input int idx, input logic [DATA_W-1:0] b);
        mem_word_u w;
        w.code = b;                      // Chip address keeps the whole byte
        if (idx == 1 || idx == 2) begin
            w.setting.spare = 2'b00;     // Rows keep a 6-bit value
        end else if (idx > 2) begin
            w.code = {4'h0, b[3:0]};     // Low nibble only
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_word(input string what, input mem_word_u got, input mem_word_u exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s: got 8'h%02h, expected 8'h%02h",
                                $time, what, got.code, exp.code));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_quiet();
        check_count("pulse and level outputs",
                    int'({rst_pulse, rst, start_pulse, start, stop_pulse, stop}), 0);
        check_count("mem_en before the first read", int'(mem_en), 0);
        check_count("mem_we", int'(mem_we), 0);
        for (int i = 0; i < NUM_SET; i++) begin
            check_word(set_name[i], settings_word(i), '0);
        end
    endtask

    // Samples at the falling edge and returns on the rising edge
    task automatic next_cycle();
        @(negedge CLK);
        cur_slot  = i_dut.i_slot_sequencer.slot;
        cur_phase = i_dut.i_slot_sequencer.phase;
        a_sample  = a_rdata;
        pulse_cnt[0] += int'(rst_pulse);
        pulse_cnt[1] += int'(start_pulse);
        pulse_cnt[2] += int'(stop_pulse);
        level_cnt[0] += int'(rst);
        level_cnt[1] += int'(start);
        level_cnt[2] += int'(stop);
        if (quiet_window && cur_slot == SLOT_W'(1) && cur_phase == PHASE_W'(FIRST_READ_PHASE))
        begin
            quiet_window = 1'b0;   // First read reaches the port now
            check_count("mem_en at the first read", int'(mem_en), 1);
        end else if (quiet_window) begin
            check_quiet();
        end
        @(posedge CLK);
    endtask

    task automatic wait_slot(input int slot_no, input int phase_no);
        do begin
            next_cycle();
        end while (cur_slot != SLOT_W'(slot_no) || cur_phase != PHASE_W'(phase_no));
    endtask

    task automatic write_mem(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        a_en    <= 1'b1;
        a_we    <= 1'b1;
        a_addr  <= addr;
        a_wdata <= data;
        next_cycle();
    endtask

    task automatic read_mem(input logic [ADDR_W-1:0] addr, output mem_word_u data);
        a_en   <= 1'b1;
        a_we   <= 1'b0;
        a_addr <= addr;
        next_cycle();      // Memory captures the address
        a_en   <= 1'b0;
        next_cycle();
        data = a_sample;
    endtask

    task automatic set_row(input int r, input logic [STATUS_W-1:0] status,
                           input logic [DATA_W-1:0] b_rst, b_start, b_stop,
                           input logic iss_rst, iss_start, iss_stop);
        rows[r].status = status;
        rows[r].cmd    = {b_stop, b_start, b_rst};
        rows[r].issue  = {iss_stop, iss_start, iss_rst};
    endtask

    task automatic run_frame(input int r);
        logic [DATA_W-1:0] set_val [NUM_SET];
        mem_word_u got;
        mem_word_u exp;
        wait_slot(0, PHASE_HALF_FIRST);   // Just after the wrap with all reads still ahead
        pulse_cnt  = '{default: 0};
        level_cnt  = '{default: 0};
        run_status <= rows[r].status;
        for (int i = 0; i < 3; i++) begin
            write_mem(ADDR_W'(cmd_addr[i]), rows[r].cmd[i]);
        end
        for (int i = 0; i < NUM_SET; i++) begin
            rng        = xorshift32(rng);
            set_val[i] = rng[DATA_W-1:0];
            write_mem(ADDR_W'(set_addr[i]), set_val[i]);
        end
        a_en <= 1'b0;
        a_we <= 1'b0;
        wait_slot(SLOT_RUN_STATUS + 1, PHASE_HALF_FIRST);   // Write slots over
        for (int i = 0; i < NUM_SET; i++) begin
            check_word(set_name[i], settings_word(i), expected_setting(i, set_val[i]));
        end
        for (int i = 0; i < 3; i++) begin
            check_count({cmd_name[i], "_pulse cycles"}, pulse_cnt[i], int'(rows[r].issue[i]));
            check_count({cmd_name[i], " level cycles"}, level_cnt[i],
                        rows[r].issue[i] ? 1 + STRETCH_CLOCKS : 0);
            read_mem(ADDR_W'(cmd_addr[i]), got);
            exp.code = rows[r].issue[i] ? '0 : rows[r].cmd[i];   // Cleared once issued
            check_word({cmd_name[i], " byte after frame"}, got, exp);
        end
        read_mem(ADDR_W'(ADDR_RUN_STATUS), got);
        exp.code = DATA_W'(rows[r].status);
        check_word("run status byte", got, exp);
    endtask

    initial begin
        gen_reset    = 1'b1;
        run_status   = '0;
        a_en         = 1'b0;
        a_we         = 1'b0;
        a_addr       = '0;
        a_wdata      = '0;
        rng          = 32'h215;
        quiet_window = 1'b1;
        //      row status  rst    start  stop   issue rst, start, stop
        set_row(0, 3'd1, 8'h0F, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
        set_row(1, 3'd1, 8'h00, 8'h0F, 8'h00, 1'b0, 1'b1, 1'b0);
        set_row(2, 3'd5, 8'h0F, 8'h0F, 8'h0F, 1'b1, 1'b1, 1'b1);
        set_row(3, 3'd2, 8'h0E, 8'h1F, 8'hF0, 1'b0, 1'b0, 1'b0);
        set_row(4, 3'd7, 8'h0F, 8'h8F, 8'h0F, 1'b1, 1'b0, 1'b1);
        set_row(5, 3'd0, 8'h00, 8'h00, 8'h0F, 1'b0, 1'b0, 1'b1);
        repeat (8) begin
            next_cycle();
        end
        gen_reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_frame(r);   // First frame after reset runs on the empty map
        end
        $display("test passed");
        $finish;
    end

endmodule

/* dv/cmd_memory_model.sv */
module cmd_memory_model
    import poll_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic              CLK,
    // Port A, testbench side
    input  logic              a_en,
    input  logic              a_we,
    input  logic [ADDR_W-1:0] a_addr,
    input  logic [DATA_W-1:0] a_wdata,
    output logic [DATA_W-1:0] a_rdata,
    // Port B, DUT side
    input  logic              b_en,
    input  logic              b_we,
    input  logic [ADDR_W-1:0] b_addr,
    input  logic [DATA_W-1:0] b_wdata,
    output logic [DATA_W-1:0] b_rdata
);

    logic [DATA_W-1:0] mem [DEPTH];   // Shared register map

    // Empty map, so no command byte is pending at start
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Both ports synchronous, one clock read latency
    always @(posedge CLK) begin
        if (a_en) begin
            if (a_we) begin
                mem[a_addr] <= a_wdata;
            end
            a_rdata <= mem[a_addr];   // Old data on a write
        end
        if (b_en) begin
            if (b_we) begin
                mem[b_addr] <= b_wdata;
            end
            b_rdata <= mem[b_addr];
        end
    end

endmodule

/* source/user_command_gen.sv */
module user_command_gen
    import poll_pkg::*;
#(
    parameter int SLOT_CLOCKS    = 10,
    parameter int SCAN_SLOTS     = 64,
    parameter int STRETCH_CLOCKS = 4
) (
    input  logic                CLK,
    input  logic                gen_reset,
    input  logic [DATA_W-1:0]   mem_rdata,
    input  logic [STATUS_W-1:0] run_status,
    output logic                mem_en,
    output logic                mem_we,
    output logic [ADDR_W-1:0]   mem_addr,
    output logic [DATA_W-1:0]   mem_wdata,
    output logic [DATA_W-1:0]   chip_address,
    output logic [ROW_W-1:0]    row_read_start,
    output logic [ROW_W-1:0]    row_read_end,
    output logic [COL_W-1:0]    column_read_start,
    output logic [COL_W-1:0]    column_read_end,
    output logic [DELAY_W-1:0]  time_delay,
    output logic                rst_pulse,
    output logic                rst,
    output logic                start_pulse,
    output logic                start,
    output logic                stop_pulse,
    output logic                stop
);

    logic [PHASE_W-1:0] phase;
    logic [SLOT_W-1:0]  slot;

    // Read side to port
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;

    // Issue flags, read side to write side
    logic rst_flag;
    logic start_flag;
    logic stop_flag;

    // Write side to port
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    slot_sequencer #(
        .SLOT_CLOCKS (SLOT_CLOCKS),
        .SCAN_SLOTS  (SCAN_SLOTS)
    ) i_slot_sequencer (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .phase     (phase),
        .slot      (slot)
    );

    command_decoder #(
        .STRETCH_CLOCKS (STRETCH_CLOCKS)
    ) i_command_decoder (
        .CLK               (CLK),
        .gen_reset         (gen_reset),
        .phase             (phase),
        .slot              (slot),
        .mem_rdata         (mem_rdata),     // Straight from the memory
        .rd_en             (rd_en),
        .rd_addr           (rd_addr),
        .rst_flag          (rst_flag),
        .start_flag        (start_flag),
        .stop_flag         (stop_flag),
        .chip_address      (chip_address),
        .row_read_start    (row_read_start),
        .row_read_end      (row_read_end),
        .column_read_start (column_read_start),
        .column_read_end   (column_read_end),
        .time_delay        (time_delay),
        .rst_pulse         (rst_pulse),
        .rst               (rst),
        .start_pulse       (start_pulse),
        .start             (start),
        .stop_pulse        (stop_pulse),
        .stop              (stop)
    );

    status_writeback i_status_writeback (
        .CLK        (CLK),
        .gen_reset  (gen_reset),
        .phase      (phase),
        .slot       (slot),
        .rst_flag   (rst_flag),
        .start_flag (start_flag),
        .stop_flag  (stop_flag),
        .run_status (run_status),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    mem_port_mux i_mem_port_mux (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

endmodule

/* source/mem_port_mux.sv */
module mem_port_mux
    import poll_pkg::*;
(
    input  logic              CLK,
    input  logic              gen_reset,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    output logic              mem_en,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata
);

    // Port strobes
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            mem_en <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            mem_en <= rd_en || wr_en;
            mem_we <= wr_en;
        end
    end

    // Address select, write side wins a clash
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem_addr <= wr_addr;
        end else begin
            mem_addr <= rd_addr;
        end
        mem_wdata <= wr_data;   // Only sampled by the memory with mem_we
    end

endmodule

/* source/status_writeback.sv */
module status_writeback
    import poll_pkg::*;
(
    input  logic                CLK,
    input  logic                gen_reset,
    input  logic [PHASE_W-1:0]  phase,
    input  logic [SLOT_W-1:0]   slot,
    input  logic                rst_flag,
    input  logic                start_flag,
    input  logic                stop_flag,
    input  logic [STATUS_W-1:0] run_status,
    output logic                wr_en,
    output logic [ADDR_W-1:0]   wr_addr,
    output logic [DATA_W-1:0]   wr_data
);

    logic half;   // Write window inside the slot

    assign half = (phase >= PHASE_W'(PHASE_HALF_FIRST)) &&
                  (phase <= PHASE_W'(PHASE_HALF_LAST));

    // Enable is control state
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            wr_en <= 1'b0;
        end else if (half) begin
            case (slot)
                SLOT_W'(SLOT_CLR_RESET):  wr_en <= rst_flag;     // Only if issued
                SLOT_W'(SLOT_CLR_START):  wr_en <= start_flag;
                SLOT_W'(SLOT_CLR_STOP):   wr_en <= stop_flag;
                SLOT_W'(SLOT_RUN_STATUS): wr_en <= 1'b1;         // Every frame
                default:                  wr_en <= 1'b0;
            endcase
        end else begin
            wr_en <= 1'b0;
        end
    end

    // Address and data, valid whenever wr_en is
    always_ff @(posedge CLK) begin
        case (slot)
            SLOT_W'(SLOT_CLR_RESET): begin
                wr_addr <= ADDR_W'(ADDR_RESET);
                wr_data <= '0;              // Erase the command byte
            end
            SLOT_W'(SLOT_CLR_START): begin
                wr_addr <= ADDR_W'(ADDR_START);
                wr_data <= '0;
            end
            SLOT_W'(SLOT_CLR_STOP): begin
                wr_addr <= ADDR_W'(ADDR_STOP);
                wr_data <= '0;
            end
            SLOT_W'(SLOT_RUN_STATUS): begin
                wr_addr <= ADDR_W'(ADDR_RUN_STATUS);
                wr_data <= DATA_W'(run_status);   // Zero-extended
            end
            default: ;
        endcase
    end

endmodule

/* source/command_decoder.sv */
module command_decoder
    import poll_pkg::*;
#(
    parameter int STRETCH_CLOCKS = 4
) (
    input  logic                CLK,
    input  logic                gen_reset,
    input  logic [PHASE_W-1:0]  phase,
    input  logic [SLOT_W-1:0]   slot,
    input  logic [DATA_W-1:0]   mem_rdata,
    output logic                rd_en,
    output logic [ADDR_W-1:0]   rd_addr,
    output logic                rst_flag,
    output logic                start_flag,
    output logic                stop_flag,
    output logic [DATA_W-1:0]   chip_address,
    output logic [ROW_W-1:0]    row_read_start,
    output logic [ROW_W-1:0]    row_read_end,
    output logic [COL_W-1:0]    column_read_start,
    output logic [COL_W-1:0]    column_read_end,
    output logic [DELAY_W-1:0]  time_delay,
    output logic                rst_pulse,
    output logic                rst,
    output logic                start_pulse,
    output logic                start,
    output logic                stop_pulse,
    output logic                stop
);

    mem_word_u word_q;      // Single input register
    logic      check;
    logic      issue;       // Current byte is a command code
    logic      issue_rst;
    logic      issue_start;
    logic      issue_stop;

    // Read address follows the slot, one clock behind
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            rd_en   <= 1'b0;
            rd_addr <= '0;
        end else if (slot >= SLOT_W'(1) && slot <= SLOT_W'(READ_LAST)) begin
            rd_en   <= 1'b1;
            rd_addr <= slot[ADDR_W-1:0];   // Slot number is the address
        end else begin
            rd_en   <= 1'b0;
            rd_addr <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        word_q <= mem_rdata;    // Sampled every clock, used only at the check
    end

    assign check       = (phase == PHASE_W'(PHASE_CHECK));
    assign issue       = check && (word_q.code == CMD_ISSUE);
    assign issue_rst   = issue && (slot == SLOT_W'(ADDR_RESET));
    assign issue_start = issue && (slot == SLOT_W'(ADDR_START));
    assign issue_stop  = issue && (slot == SLOT_W'(ADDR_STOP));

    // Setting registers
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            chip_address      <= '0;
            row_read_start    <= '0;
            row_read_end      <= '0;
            column_read_start <= '0;
            column_read_end   <= '0;
            time_delay        <= '0;
        end else if (check) begin
            case (slot)
                SLOT_W'(ADDR_CHIP):      chip_address      <= word_q.code;   // Full byte
                SLOT_W'(ADDR_ROW_START): row_read_start    <= word_q.setting.value;
                SLOT_W'(ADDR_ROW_END):   row_read_end      <= word_q.setting.value;
                SLOT_W'(ADDR_COL_START): column_read_start <= word_q.setting.value[COL_W-1:0];
                SLOT_W'(ADDR_COL_END):   column_read_end   <= word_q.setting.value[COL_W-1:0];
                SLOT_W'(ADDR_DELAY):     time_delay        <= word_q.setting.value[DELAY_W-1:0];
                default: ;
            endcase
        end
    end

    // Command pulses and issue flags
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            rst_pulse   <= 1'b0;
            start_pulse <= 1'b0;
            stop_pulse  <= 1'b0;
            rst_flag    <= 1'b0;
            start_flag  <= 1'b0;
            stop_flag   <= 1'b0;
        end else begin
            rst_pulse   <= issue_rst;     // High the clock after the check
            start_pulse <= issue_start;
            stop_pulse  <= issue_stop;
            if (slot == '0) begin
                // New frame, nothing issued yet
                rst_flag   <= 1'b0;
                start_flag <= 1'b0;
                stop_flag  <= 1'b0;
            end else begin
                if (issue_rst)   rst_flag   <= 1'b1;
                if (issue_start) start_flag <= 1'b1;
                if (issue_stop)  stop_flag  <= 1'b1;
            end
        end
    end

    // Level outputs
    pulse_stretcher #(.STRETCH_CLOCKS(STRETCH_CLOCKS)) i_rst_stretch (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .pulse     (rst_pulse),
        .level     (rst)
    );

    pulse_stretcher #(.STRETCH_CLOCKS(STRETCH_CLOCKS)) i_start_stretch (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .pulse     (start_pulse),
        .level     (start)
    );

    pulse_stretcher #(.STRETCH_CLOCKS(STRETCH_CLOCKS)) i_stop_stretch (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .pulse     (stop_pulse),
        .level     (stop)
    );

endmodule

/* source/pulse_stretcher.sv */
module pulse_stretcher #(
    parameter int STRETCH_CLOCKS = 4
) (
    input  logic CLK,
    input  logic gen_reset,
    input  logic pulse,
    output logic level
);

    localparam int CNT_W = (STRETCH_CLOCKS > 0) ? $clog2(STRETCH_CLOCKS + 1) : 1;

    logic [CNT_W-1:0] run_cnt;   // Clocks still to hold after the pulse

    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            run_cnt <= '0;
        end else if (pulse) begin
            run_cnt <= CNT_W'(STRETCH_CLOCKS);   // Restart on every pulse
        end else if (run_cnt != '0) begin
            run_cnt <= run_cnt - 1'b1;
        end
    end

    // Pulse clock itself plus the counted tail
    assign level = pulse || (run_cnt != '0);

endmodule

/* source/slot_sequencer.sv */
module slot_sequencer
    import poll_pkg::*;
#(
    parameter int SLOT_CLOCKS = 10,
    parameter int SCAN_SLOTS  = 64
) (
    input  logic               CLK,
    input  logic               gen_reset,
    output logic [PHASE_W-1:0] phase,
    output logic [SLOT_W-1:0]  slot
);

    logic phase_last;   // Final clock of a slot
    logic slot_last;    // Final slot of a frame
    logic switch_now;

    assign phase_last = (phase == PHASE_W'(SLOT_CLOCKS - 1));
    assign slot_last  = (slot == SLOT_W'(SCAN_SLOTS - 1));
    assign switch_now = (phase == PHASE_W'(PHASE_SWITCH));

    // Phase counter, one lap per slot
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            phase <= '0;
        end else if (phase_last) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Slot counter steps once per slot, new value first seen at phase 2
    always_ff @(posedge CLK) begin
        if (gen_reset) begin
            slot <= '0;
        end else if (switch_now) begin
            if (slot_last) begin
                slot <= '0;     // Frame wrap
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

endmodule

/* source/poll_pkg.sv */
package poll_pkg;

    // Memory port widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = 5;

    // Sequencer counter widths, wide enough for any slot length and frame
    localparam int PHASE_W = 8;
    localparam int SLOT_W  = 8;

    // Command bytes
    localparam int ADDR_RESET      = 1;
    localparam int ADDR_START      = 3;
    localparam int ADDR_STOP       = 4;
    localparam int ADDR_RUN_STATUS = 7;   // Written back, never read for control

    // Readout settings
    localparam int ADDR_CHIP      = 8;
    localparam int ADDR_ROW_START = 10;
    localparam int ADDR_ROW_END   = 11;
    localparam int ADDR_COL_START = 12;
    localparam int ADDR_COL_END   = 13;
    localparam int ADDR_DELAY     = 15;   // Conversion clock delay

    localparam int READ_LAST = 23;        // Slots 1 to 23 read the memory

    // Write slots, well clear of the read slots
    localparam int SLOT_CLR_RESET  = 33;
    localparam int SLOT_CLR_START  = 37;
    localparam int SLOT_CLR_STOP   = 39;
    localparam int SLOT_RUN_STATUS = 41;

    // Phases inside one slot
    localparam int PHASE_SWITCH     = 1;  // Slot counter steps here
    localparam int PHASE_HALF_FIRST = 2;  // Write window start
    localparam int PHASE_HALF_LAST  = 6;  // Write window end
    localparam int PHASE_CHECK      = 7;  // Read data is stable by now

    localparam logic [DATA_W-1:0] CMD_ISSUE = 8'h0F;

    localparam int ROW_W    = 6;
    localparam int COL_W    = 4;
    localparam int DELAY_W  = 4;
    localparam int STATUS_W = 3;

    // One memory byte, either a command code or a setting value
    typedef union packed {
        logic [DATA_W-1:0] code;          // Whole byte vs CMD_ISSUE
        struct packed {
            logic [1:0]       spare;
            logic [ROW_W-1:0] value;      // Rows use all 6 bits, others the low 4
        } setting;
    } mem_word_u;

endpackage
